/* rtl/bp_pkg.sv */
package bp_pkg;

    ////////////////////////////////////////
    // counter encoding
    ////////////////////////////////////////

    // 2-bit saturating counter
    // 0,1 -> not taken / use bimodal
    // 2,3 -> taken / use gshare
    typedef logic [1:0] ctr_t;

    // saturation bounds
    localparam ctr_t CTR_MIN = 2'd0;
    localparam ctr_t CTR_MAX = 2'd3;

    // weakly not taken, weakly bimodal
    localparam ctr_t CTR_RESET = 2'd1;

    ////////////////////////////////////////
    // counter helpers
    ////////////////////////////////////////

    // step toward 3, stick at top
    function automatic ctr_t ctr_inc(input ctr_t ctr);
        ctr_inc = (ctr == CTR_MAX) ? ctr : ctr + 2'd1;
    endfunction

    // step toward 0, stick at bottom
    function automatic ctr_t ctr_dec(input ctr_t ctr);
        ctr_dec = (ctr == CTR_MIN) ? ctr : ctr - 2'd1;
    endfunction

    // upper bit is the decision
    function automatic logic ctr_high(input ctr_t ctr);
        ctr_high = ctr[1];
    endfunction

endpackage : bp_pkg

/* rtl/bp_resolve_if.sv */
`timescale 1ns/100ps

interface bp_resolve_if #(
    parameter int INDEX_W = 6
) ();

    // resolution strobe, all fields below valid with it
    logic resolve_valid;

    // actual branch direction
    logic outcome;

    // raw branch index, bimodal and chooser slot
    logic [INDEX_W-1:0] pc_index;

    // hashed index captured at lookup time
    logic [INDEX_W-1:0] gshare_index;

    // component predictions captured at lookup time
    logic gshare_pred;
    logic bimodal_pred;

    // queue side
    modport source (
        output resolve_valid, outcome, pc_index, gshare_index, gshare_pred, bimodal_pred
    );

    // table side
    modport sink (
        input resolve_valid, outcome, pc_index, gshare_index, gshare_pred, bimodal_pred
    );

endinterface : bp_resolve_if

/* rtl/inflight_queue.sv */
`timescale 1ns/100ps

module inflight_queue #(
    parameter int INDEX_W     = 6,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // lookup side
    input  logic               push_i,
    input  logic [INDEX_W-1:0] pc_index_i,
    input  logic [INDEX_W-1:0] gshare_index_i,
    input  logic               gshare_pred_i,
    input  logic               bimodal_pred_i,
    input  logic               final_pred_i,
    // execute side
    input  logic               executed_i,
    input  logic               outcome_i,
    bp_resolve_if.source       resolve,
    output logic               mispredicted_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////

    logic [PTR_W-1:0] push_ptr_q;
    logic [PTR_W-1:0] pull_ptr_q;
    // one extra bit so depth itself fits
    logic [PTR_W:0]   count_q;
    logic             full;
    logic             empty;

    // depth is a power of two, top bit only set when full
    assign full  = count_q[PTR_W];
    assign empty = (count_q == '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            push_ptr_q <= '0;
            pull_ptr_q <= '0;
            count_q    <= '0;
        end else begin
            // pointers wrap naturally
            if (push_i) begin
                push_ptr_q <= push_ptr_q + 1'b1;
            end
            if (executed_i) begin
                pull_ptr_q <= pull_ptr_q + 1'b1;
            end
            // push and pop together leave count alone
            case ({push_i, executed_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    ////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////

    // one array per field
    logic [INDEX_W-1:0] pc_index_mem     [QUEUE_DEPTH];
    logic [INDEX_W-1:0] gshare_index_mem [QUEUE_DEPTH];
    logic               gshare_pred_mem  [QUEUE_DEPTH];
    logic               bimodal_pred_mem [QUEUE_DEPTH];
    logic               final_pred_mem   [QUEUE_DEPTH];

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            pc_index_mem[push_ptr_q]     <= pc_index_i;
            gshare_index_mem[push_ptr_q] <= gshare_index_i;
            gshare_pred_mem[push_ptr_q]  <= gshare_pred_i;
            bimodal_pred_mem[push_ptr_q] <= bimodal_pred_i;
            final_pred_mem[push_ptr_q]   <= final_pred_i;
        end
    end

    ////////////////////////////////////////
    // oldest entry out
    ////////////////////////////////////////

    // head is read before the edge, so a full push+pop sees old data
    assign resolve.resolve_valid = executed_i;
    assign resolve.outcome       = outcome_i;
    assign resolve.pc_index      = pc_index_mem[pull_ptr_q];
    assign resolve.gshare_index  = gshare_index_mem[pull_ptr_q];
    assign resolve.gshare_pred   = gshare_pred_mem[pull_ptr_q];
    assign resolve.bimodal_pred  = bimodal_pred_mem[pull_ptr_q];

    // compare against the final prediction, not the components
    assign mispredicted_o = executed_i & (outcome_i ^ final_pred_mem[pull_ptr_q]);

    ////////////////////////////////////////
    // core contract
    ////////////////////////////////////////

    // lookup into a full queue only if the head leaves in that cycle
    a_no_push_full : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (push_i && full) |-> executed_i
    );

    // execute always has a prediction waiting
    a_no_pull_empty : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        executed_i |-> !empty
    );

endmodule : inflight_queue

/* rtl/gshare_predictor.sv */
`timescale 1ns/100ps

module gshare_predictor #(
    parameter int INDEX_W = 6
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               predict_i,
    input  logic [INDEX_W-1:0] index_i,
    bp_resolve_if.sink         resolve,
    output logic               gshare_pred_o,
    output logic [INDEX_W-1:0] gshare_index_o
);

    localparam int TABLE_SIZE = 1 << INDEX_W;

    ////////////////////////////////////////
    // global history
    ////////////////////////////////////////

    logic [INDEX_W-1:0] history_q;

    // non-speculative, only resolved outcomes enter
    // newest bit at position 0
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            history_q <= '0;
        end else if (resolve.resolve_valid) begin
            history_q <= {history_q[INDEX_W-2:0], resolve.outcome};
        end
    end

    ////////////////////////////////////////
    // pattern table
    ////////////////////////////////////////

    bp_pkg::ctr_t pht_q [TABLE_SIZE];
    bp_pkg::ctr_t upd_ctr;

    // hash of the lookup, also stored in the queue
    assign gshare_index_o = history_q ^ index_i;

    // nothing meaningful without a btb hit
    assign gshare_pred_o = predict_i & bp_pkg::ctr_high(pht_q[gshare_index_o]);

    // train the slot used at lookup, not the current hash
    assign upd_ctr = pht_q[resolve.gshare_index];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                pht_q[i] <= bp_pkg::CTR_RESET;
            end
        end else if (resolve.resolve_valid) begin
            // same-cycle lookup still reads the old value
            if (resolve.outcome) begin
                pht_q[resolve.gshare_index] <= bp_pkg::ctr_inc(upd_ctr);
            end else begin
                pht_q[resolve.gshare_index] <= bp_pkg::ctr_dec(upd_ctr);
            end
        end
    end

endmodule : gshare_predictor

/* rtl/bimodal_predictor.sv */
`timescale 1ns/100ps

module bimodal_predictor #(
    parameter int INDEX_W = 6
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic [INDEX_W-1:0] index_i,
    bp_resolve_if.sink         resolve,
    output logic               bimodal_pred_o
);

    localparam int TABLE_SIZE = 1 << INDEX_W;

    ////////////////////////////////////////
    // per-branch counters
    ////////////////////////////////////////

    bp_pkg::ctr_t bht_q [TABLE_SIZE];
    bp_pkg::ctr_t upd_ctr;

    // plain index lookup, no history
    assign bimodal_pred_o = bp_pkg::ctr_high(bht_q[index_i]);

    // counter of the branch being resolved
    assign upd_ctr = bht_q[resolve.pc_index];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                bht_q[i] <= bp_pkg::CTR_RESET;
            end
        end else if (resolve.resolve_valid) begin
            // move toward actual direction
            if (resolve.outcome) begin
                bht_q[resolve.pc_index] <= bp_pkg::ctr_inc(upd_ctr);
            end else begin
                bht_q[resolve.pc_index] <= bp_pkg::ctr_dec(upd_ctr);
            end
        end
    end

endmodule : bimodal_predictor

/* rtl/tournament_chooser.sv */
`timescale 1ns/100ps

module tournament_chooser #(
    parameter int INDEX_W = 6
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic [INDEX_W-1:0] index_i,
    input  logic               gshare_pred_i,
    input  logic               bimodal_pred_i,
    bp_resolve_if.sink         resolve,
    output logic               prediction_o
);

    localparam int TABLE_SIZE = 1 << INDEX_W;

    ////////////////////////////////////////
    // chooser table
    ////////////////////////////////////////

    bp_pkg::ctr_t choice_q [TABLE_SIZE];
    bp_pkg::ctr_t upd_ctr;
    logic         disagree;
    logic         gshare_right;

    // high half picks gshare
    assign prediction_o = bp_pkg::ctr_high(choice_q[index_i]) ? gshare_pred_i
                                                              : bimodal_pred_i;

    // only learn when the components disagree
    assign disagree     = resolve.gshare_pred ^ resolve.bimodal_pred;
    assign gshare_right = (resolve.gshare_pred == resolve.outcome);
    assign upd_ctr      = choice_q[resolve.pc_index];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                choice_q[i] <= bp_pkg::CTR_RESET;
            end
        end else if (resolve.resolve_valid && disagree) begin
            // exactly one side was right here
            if (gshare_right) begin
                choice_q[resolve.pc_index] <= bp_pkg::ctr_inc(upd_ctr);
            end else begin
                choice_q[resolve.pc_index] <= bp_pkg::ctr_dec(upd_ctr);
            end
        end
    end

    ////////////////////////////////////////
    // resolve bus sanity
    ////////////////////////////////////////

    // queue head must hold a real entry when the strobe fires
    a_resolve_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        resolve.resolve_valid |-> !$isunknown({resolve.outcome, resolve.pc_index,
                                               resolve.gshare_index, resolve.gshare_pred,
                                               resolve.bimodal_pred})
    );

endmodule : tournament_chooser

/* rtl/branch_predictor_top.sv */
`timescale 1ns/100ps

module branch_predictor_top #(
    parameter int INDEX_W     = 6,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // btb hit, lookup this cycle
    input  logic               predict_i,
    input  logic [INDEX_W-1:0] index_i,
    // branch resolved in execute
    input  logic               executed_i,
    input  logic               outcome_i,
    output logic               prediction_o,
    output logic               mispredicted_o
);

    ////////////////////////////////////////
    // lookup wires
    ////////////////////////////////////////

    logic               gshare_pred;
    logic [INDEX_W-1:0] gshare_index;
    logic               bimodal_pred;
    logic               final_pred;

    // oldest entry to all three tables
    bp_resolve_if #(.INDEX_W(INDEX_W)) resolve_bus ();

    gshare_predictor #(.INDEX_W(INDEX_W)) gshare_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .predict_i      (predict_i),
        .index_i        (index_i),
        .resolve        (resolve_bus.sink),
        .gshare_pred_o  (gshare_pred),
        .gshare_index_o (gshare_index)
    );

    bimodal_predictor #(.INDEX_W(INDEX_W)) bimodal_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .index_i        (index_i),
        .resolve        (resolve_bus.sink),
        .bimodal_pred_o (bimodal_pred)
    );

    tournament_chooser #(.INDEX_W(INDEX_W)) chooser_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .index_i        (index_i),
        .gshare_pred_i  (gshare_pred),
        .bimodal_pred_i (bimodal_pred),
        .resolve        (resolve_bus.sink),
        .prediction_o   (final_pred)
    );

    ////////////////////////////////////////
    // in-flight tracking
    ////////////////////////////////////////

    // every btb hit allocates an entry
    inflight_queue #(
        .INDEX_W     (INDEX_W),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .push_i         (predict_i),
        .pc_index_i     (index_i),
        .gshare_index_i (gshare_index),
        .gshare_pred_i  (gshare_pred),
        .bimodal_pred_i (bimodal_pred),
        .final_pred_i   (final_pred),
        .executed_i     (executed_i),
        .outcome_i      (outcome_i),
        .resolve        (resolve_bus.source),
        .mispredicted_o (mispredicted_o)
    );

    assign prediction_o = final_pred;

endmodule : branch_predictor_top

/* bench/bp_checker.sv */
`timescale 1ns/100ps

module bp_checker #(
    parameter int INDEX_W = 6
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               predict_i,
    input  logic [INDEX_W-1:0] index_i,
    input  logic               executed_i,
    input  logic               outcome_i,
    input  logic               prediction_i,
    input  logic               mispredicted_i,
    output int                 error_count_o
);

    localparam int TABLE_SIZE = 1 << INDEX_W;

    ////////////////////////////////////////
    // reference state
    ////////////////////////////////////////

    logic [1:0]         gshare_tbl  [TABLE_SIZE];
    logic [1:0]         bimodal_tbl [TABLE_SIZE];
    logic [1:0]         choice_tbl  [TABLE_SIZE];
    logic [INDEX_W-1:0] history;

    // outstanding predictions, oldest at the front
    logic [INDEX_W-1:0] pc_fifo    [$];
    logic [INDEX_W-1:0] gidx_fifo  [$];
    logic               gpred_fifo [$];
    logic               bpred_fifo [$];
    logic               fpred_fifo [$];

    int errors = 0;
    assign error_count_o = errors;

    // 2-bit saturating step toward the outcome
    function automatic logic [1:0] sat_step(input logic [1:0] c, input logic up);
        if (up && c != 2'd3) begin
            sat_step = c + 2'd1;
        end else if (!up && c != 2'd0) begin
            sat_step = c - 2'd1;
        end else begin
            sat_step = c;
        end
    endfunction

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %0t ns %s expected %0b got %0b", $time, name, exp, act);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // per-edge model step
    ////////////////////////////////////////

    always @(posedge clk_i) begin
        logic [INDEX_W-1:0] hidx;
        logic               g_pred;
        logic               b_pred;
        logic               f_pred;
        logic               exp_miss;
        logic [INDEX_W-1:0] r_pc;
        logic [INDEX_W-1:0] r_gidx;
        logic               r_gp;
        logic               r_bp;
        logic               r_fp;

        if (!rst_n_i) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                gshare_tbl[i]  = 2'd1;
                bimodal_tbl[i] = 2'd1;
                choice_tbl[i]  = 2'd1;
            end
            history = '0;
            pc_fifo.delete();
            gidx_fifo.delete();
            gpred_fifo.delete();
            bpred_fifo.delete();
            fpred_fifo.delete();
        end else begin
            // lookup sees state from before this edge
            hidx   = history ^ index_i;
            g_pred = gshare_tbl[hidx][1];
            b_pred = bimodal_tbl[index_i][1];
            f_pred = choice_tbl[index_i][1] ? g_pred : b_pred;
            if (predict_i) begin
                compare_bit("prediction_o", f_pred, prediction_i);
            end
            exp_miss = 1'b0;
            if (executed_i) begin
                if (pc_fifo.size() == 0) begin
                    $display("at %0t ns a branch executed with no prediction outstanding",
                             $time);
                    errors++;
                end else begin
                    r_pc     = pc_fifo.pop_front();
                    r_gidx   = gidx_fifo.pop_front();
                    r_gp     = gpred_fifo.pop_front();
                    r_bp     = bpred_fifo.pop_front();
                    r_fp     = fpred_fifo.pop_front();
                    exp_miss = (outcome_i != r_fp);
                    gshare_tbl[r_gidx] = sat_step(gshare_tbl[r_gidx], outcome_i);
                    bimodal_tbl[r_pc]  = sat_step(bimodal_tbl[r_pc], outcome_i);
                    // chooser learns only on disagreement
                    if (r_gp != r_bp) begin
                        choice_tbl[r_pc] = sat_step(choice_tbl[r_pc], r_gp == outcome_i);
                    end
                    history = {history[INDEX_W-2:0], outcome_i};
                end
            end
            // low whenever nothing resolves
            compare_bit("mispredicted_o", exp_miss, mispredicted_i);
            if (predict_i) begin
                pc_fifo.push_back(index_i);
                gidx_fifo.push_back(hidx);
                gpred_fifo.push_back(g_pred);
                bpred_fifo.push_back(b_pred);
                fpred_fifo.push_back(f_pred);
            end
        end
    end

endmodule : bp_checker

/* bench/tb_branch_predictor.sv */
`timescale 1ns/100ps

module tb_branch_predictor;

    localparam int INDEX_W     = 6;
    localparam int QUEUE_DEPTH = 4;
    localparam int MAX_ROWS    = 256;
    localparam int CLK_PERIOD  = 100;

    logic               clk;
    logic               rst_n;
    logic               predict;
    logic [INDEX_W-1:0] index;
    logic               executed;
    logic               outcome;
    logic               prediction;
    logic               mispredicted;
    int                 error_count;

    // stimulus table, one row per cycle
    logic               row_predict [MAX_ROWS];
    logic [INDEX_W-1:0] row_index   [MAX_ROWS];
    logic               row_execute [MAX_ROWS];
    logic               row_outcome [MAX_ROWS];
    int                 row_count;
    // queue fill as the table is built
    int                 occupancy;
    logic [31:0]        lfsr_state;
    logic               table_ready;

    branch_predictor_top #(
        .INDEX_W     (INDEX_W),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) branch_predictor_top_i (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .predict_i      (predict),
        .index_i        (index),
        .executed_i     (executed),
        .outcome_i      (outcome),
        .prediction_o   (prediction),
        .mispredicted_o (mispredicted)
    );

    bp_checker #(.INDEX_W(INDEX_W)) checker_i (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .predict_i      (predict),
        .index_i        (index),
        .executed_i     (executed),
        .outcome_i      (outcome),
        .prediction_i   (prediction),
        .mispredicted_i (mispredicted),
        .error_count_o  (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // random bits and table building
    ////////////////////////////////////////

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function logic next_random_bit();
        lfsr_state      = lfsr_next(lfsr_state);
        next_random_bit = lfsr_state[0];
    endfunction

    task automatic add_row(input logic p, input logic [INDEX_W-1:0] idx,
                           input logic e, input logic o);
        row_predict[row_count] = p;
        row_index[row_count]   = idx;
        row_execute[row_count] = e;
        row_outcome[row_count] = o;
        row_count++;
        occupancy = occupancy + (p ? 1 : 0) - (e ? 1 : 0);
    endtask

    task automatic drain_queue();
        while (occupancy > 0) begin
            add_row(1'b0, '0, 1'b1, next_random_bit());
        end
    endtask

    task automatic build_table();
        logic               p;
        logic               e;
        logic               o;
        logic [INDEX_W-1:0] idx;

        // first lookup after reset, then taken resolve
        add_row(1'b1, 6'd5, 1'b0, 1'b0);
        add_row(1'b0, 6'd0, 1'b1, 1'b1);
        // one branch always taken
        repeat (3) begin
            add_row(1'b1, 6'd10, 1'b0, 1'b0);
            add_row(1'b0, 6'd0, 1'b1, 1'b1);
        end
        // neighbour index should be untouched
        add_row(1'b1, 6'd11, 1'b0, 1'b0);
        add_row(1'b0, 6'd0, 1'b1, 1'b0);
        // alternating pattern, history picks it up
        for (int i = 0; i < 24; i++) begin
            add_row(1'b1, 6'd20, 1'b0, 1'b0);
            add_row(1'b0, 6'd0, 1'b1, i[0]);
        end
        // lookup and update of the same slot in one cycle
        add_row(1'b1, 6'd30, 1'b0, 1'b0);
        add_row(1'b1, 6'd30, 1'b1, 1'b1);
        add_row(1'b0, 6'd0, 1'b1, 1'b0);
        // fill the queue, overlap, then empty it
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            add_row(1'b1, 6'(40 + i), 1'b0, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            add_row(1'b1, 6'(44 + i), 1'b1, next_random_bit());
        end
        drain_queue();
        // mixed traffic on a few hot branches
        for (int i = 0; i < 80; i++) begin
            p   = next_random_bit();
            e   = next_random_bit();
            idx = '0;
            for (int b = 0; b < 3; b++) begin
                idx[b] = next_random_bit();
            end
            o = next_random_bit();
            if (occupancy == 0) begin
                e = 1'b0;
            end
            if (occupancy == QUEUE_DEPTH && p) begin
                e = 1'b1;
            end
            add_row(p, idx, e, o);
        end
        drain_queue();
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        predict     = 1'b0;
        index       = '0;
        executed    = 1'b0;
        outcome     = 1'b0;
        lfsr_state  = 32'h254323e1;
        row_count   = 0;
        occupancy   = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // inputs change only on falling edges
        for (int r = 0; r < row_count; r++) begin
            predict  = row_predict[r];
            index    = row_index[r];
            executed = row_execute[r];
            outcome  = row_outcome[r];
            @(negedge clk);
        end
        predict  = 1'b0;
        executed = 1'b0;
        @(negedge clk);
        $display("%0d rows applied, %0d errors", row_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog sized by the table length
    initial begin
        wait (table_ready);
        #((row_count + 20) * CLK_PERIOD);
        $display("watchdog expired before the stimulus table completed");
        $display("Finished with errors");
        $finish;
    end

endmodule : tb_branch_predictor

/* verilog.f */
rtl/bp_pkg.sv
rtl/bp_resolve_if.sv
rtl/inflight_queue.sv
rtl/gshare_predictor.sv
rtl/bimodal_predictor.sv
rtl/tournament_chooser.sv
rtl/branch_predictor_top.sv
bench/bp_checker.sv
bench/tb_branch_predictor.sv

/* run_sim.sh */
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_branch_predictor -f verilog.f -o Vtb_branch_predictor
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_branch_predictor > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    echo "FAILED"
    exit 1
fi
echo "PASSED"
exit 0
